/* Makefile */
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= tb_hci_ecc_manager
RTL_TOP    ?= hci_ecc_manager
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The exit status comes from the search for the pass message
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* src.f */
verilog/hci_ecc_pkg.sv
verilog/popcount.sv
verilog/periph_to_reg.sv
verilog/hci_ecc_manager_reg_top.sv
verilog/hci_ecc_manager.sv
tb/tb_hci_ecc_manager.sv

/* tb/tb_hci_ecc_manager.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_hci_ecc_manager;

  localparam int unsigned TIMEOUT_CYCLES = 20;

  // Each expected response is queued when its request is granted
  typedef struct packed {
    hci_ecc_pkg::data_t rdata;
    logic               opc;
    hci_ecc_pkg::id_t   id;
    int unsigned        cyc;
  } rsp_t;

  logic                     clk_i;
  logic                     arst_n_i;
  logic                     periph_req_i;
  hci_ecc_pkg::addr_t       periph_add_i;
  logic                     periph_wen_i;
  hci_ecc_pkg::data_t       periph_wdata_i;
  hci_ecc_pkg::be_t         periph_be_i;
  hci_ecc_pkg::id_t         periph_id_i;
  logic                     periph_gnt_o;
  hci_ecc_pkg::data_t       periph_r_rdata_o;
  logic                     periph_r_opc_o;
  hci_ecc_pkg::id_t         periph_r_id_o;
  logic                     periph_r_valid_o;
  hci_ecc_pkg::data_flags_t data_correctable_err_i;
  hci_ecc_pkg::data_flags_t data_uncorrectable_err_i;
  hci_ecc_pkg::meta_flags_t meta_correctable_err_i;
  hci_ecc_pkg::meta_flags_t meta_uncorrectable_err_i;

  hci_ecc_pkg::cnt_t model_cnt [hci_ecc_pkg::N_CNT];
  rsp_t              exp_q [$];
  int unsigned       cycle_cnt = 0;
  int unsigned       err_cnt = 0;
  int unsigned       test_cnt = 0;
  int unsigned       test_fail_cnt = 0;
  int unsigned       test_err_start = 0;
  string             test_name = "";
  int                seed = 32'h5860411a;

  hci_ecc_manager hci_ecc_manager_inst (
    .clk_i                    ( clk_i                    ),
    .arst_n_i                 ( arst_n_i                 ),
    .periph_req_i             ( periph_req_i             ),
    .periph_add_i             ( periph_add_i             ),
    .periph_wen_i             ( periph_wen_i             ),
    .periph_wdata_i           ( periph_wdata_i           ),
    .periph_be_i              ( periph_be_i              ),
    .periph_id_i              ( periph_id_i              ),
    .periph_gnt_o             ( periph_gnt_o             ),
    .periph_r_rdata_o         ( periph_r_rdata_o         ),
    .periph_r_opc_o           ( periph_r_opc_o           ),
    .periph_r_id_o            ( periph_r_id_o            ),
    .periph_r_valid_o         ( periph_r_valid_o         ),
    .data_correctable_err_i   ( data_correctable_err_i   ),
    .data_uncorrectable_err_i ( data_uncorrectable_err_i ),
    .meta_correctable_err_i   ( meta_correctable_err_i   ),
    .meta_uncorrectable_err_i ( meta_uncorrectable_err_i )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // A software write merges its enabled bytes into the next value and drops the increment
  function automatic hci_ecc_pkg::cnt_t next_count(
    input hci_ecc_pkg::cnt_t  old_val,
    input int unsigned        n_flags,
    input logic               wr,
    input hci_ecc_pkg::data_t wdata,
    input hci_ecc_pkg::be_t   be
  );
    hci_ecc_pkg::cnt_t res;
    res = old_val;
    if (wr) begin
      for (int unsigned b = 0; b < hci_ecc_pkg::BW; b++) begin
        if (be[b]) begin
          res[8*b +: 8] = wdata[8*b +: 8];
        end
      end
    end else begin
      res = old_val + n_flags;
    end
    return res;
  endfunction

  function automatic logic [31:0] rand_word();
    rand_word = $random(seed);
  endfunction

  // Drives one cycle of bus and flag inputs and advances the model
  task automatic apply(
    input logic                     req,
    input logic                     wen,
    input hci_ecc_pkg::addr_t       addr,
    input hci_ecc_pkg::data_t       wdata,
    input hci_ecc_pkg::be_t         be,
    input hci_ecc_pkg::id_t         id,
    input hci_ecc_pkg::data_flags_t dc,
    input hci_ecc_pkg::data_flags_t du,
    input hci_ecc_pkg::meta_flags_t mc,
    input hci_ecc_pkg::meta_flags_t mu
  );
    rsp_t        rsp;
    logic        mapped;
    logic        wr;
    int unsigned idx;
    int unsigned incs [hci_ecc_pkg::N_CNT];
    @(negedge clk_i);
    periph_req_i             = req;
    periph_wen_i             = wen;
    periph_add_i             = addr;
    periph_wdata_i           = wdata;
    periph_be_i              = be;
    periph_id_i              = id;
    data_correctable_err_i   = dc;
    data_uncorrectable_err_i = du;
    meta_correctable_err_i   = mc;
    meta_uncorrectable_err_i = mu;
    mapped  = (addr[31:4] == '0) && (addr[1:0] == 2'b00);
    idx     = {30'd0, addr[3:2]};
    incs[0] = $countones(dc);
    incs[1] = $countones(du);
    incs[2] = $countones(mc);
    incs[3] = $countones(mu);
    // Reads see the value from before this cycle's update
    if (req) begin
      rsp.rdata = (wen && mapped) ? model_cnt[idx] : '0;
      rsp.opc   = ~mapped;
      rsp.id    = id;
      rsp.cyc   = cycle_cnt;
      exp_q.push_back(rsp);
    end
    for (int unsigned k = 0; k < hci_ecc_pkg::N_CNT; k++) begin
      wr = req && !wen && mapped && (idx == k);
      model_cnt[k] = next_count(model_cnt[k], incs[k], wr, wdata, be);
    end
  endtask

  task automatic idle_cycle();
    apply(1'b0, 1'b1, '0, '0, '0, '0, '0, '0, '0, '0);
  endtask

  task automatic read_reg(input hci_ecc_pkg::addr_t addr, input hci_ecc_pkg::id_t id);
    apply(1'b1, 1'b1, addr, '0, '0, id, '0, '0, '0, '0);
  endtask

  task automatic write_reg(input hci_ecc_pkg::addr_t addr, input hci_ecc_pkg::data_t data,
                           input hci_ecc_pkg::be_t be, input hci_ecc_pkg::id_t id);
    apply(1'b1, 1'b0, addr, data, be, id, '0, '0, '0, '0);
  endtask

  task automatic read_all();
    for (int unsigned k = 0; k < hci_ecc_pkg::N_CNT; k++) begin
      read_reg(hci_ecc_pkg::addr_t'(4 * k), hci_ecc_pkg::id_t'(k + 8));
    end
  endtask

  task automatic wait_responses();
    int unsigned waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited == TIMEOUT_CYCLES) begin
        $display("%s: no r_valid for %0d cycles, %0d responses still missing",
                 test_name, TIMEOUT_CYCLES, exp_q.size());
        $display("Simulation FAILED");
        $finish;
      end
      idle_cycle();
      waited++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name      = name;
    test_err_start = err_cnt;
  endtask

  task automatic end_test();
    int unsigned errs;
    wait_responses();
    idle_cycle();
    errs = err_cnt - test_err_start;
    test_cnt++;
    if (errs == 0) begin
      $display("test %s: ok", test_name);
    end else begin
      test_fail_cnt++;
      $display("test %s: %0d errors", test_name, errs);
    end
  endtask

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (periph_gnt_o !== periph_req_i) begin
      $display("%s: grant does not follow the request", test_name);
      err_cnt++;
    end
  end

  // Registered outputs are stable at the falling edge
  always @(negedge clk_i) begin : compare_rsp
    rsp_t want;
    if (arst_n_i && periph_r_valid_o === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("%s: response arrived with no request outstanding", test_name);
        err_cnt++;
      end else begin
        want = exp_q.pop_front();
        if (periph_r_rdata_o !== want.rdata) begin
          $display("ERR %s r_rdata expected %08h actual %08h",
                   test_name, want.rdata, periph_r_rdata_o);
          err_cnt++;
        end
        if (periph_r_opc_o !== want.opc) begin
          $display("ERR %s r_opc expected %0b actual %0b", test_name, want.opc, periph_r_opc_o);
          err_cnt++;
        end
        if (periph_r_id_o !== want.id) begin
          $display("ERR %s r_id expected %0h actual %0h", test_name, want.id, periph_r_id_o);
          err_cnt++;
        end
        if (cycle_cnt != want.cyc + 1) begin
          $display("%s: response came %0d cycles after its request instead of 1",
                   test_name, cycle_cnt - want.cyc);
          err_cnt++;
        end
      end
    end
  end

  initial begin
    logic [31:0] r;
    arst_n_i                 = 1'b0;
    periph_req_i             = 1'b0;
    periph_add_i             = '0;
    periph_wen_i             = 1'b1;
    periph_wdata_i           = '0;
    periph_be_i              = '0;
    periph_id_i              = '0;
    data_correctable_err_i   = '0;
    data_uncorrectable_err_i = '0;
    meta_correctable_err_i   = '0;
    meta_uncorrectable_err_i = '0;
    for (int unsigned k = 0; k < hci_ecc_pkg::N_CNT; k++) begin
      model_cnt[k] = '0;
    end
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    begin_test("reset_reads");
    if (periph_r_valid_o !== 1'b0) begin
      $display("ERR reset_reads r_valid expected 0 actual %0b", periph_r_valid_o);
      err_cnt++;
    end
    if (periph_r_opc_o !== 1'b0) begin
      $display("ERR reset_reads r_opc expected 0 actual %0b", periph_r_opc_o);
      err_cnt++;
    end
    read_all();
    end_test();

    begin_test("random_flags");
    for (int i = 0; i < 200; i++) begin
      apply(1'b0, 1'b1, '0, '0, '0, '0,
            hci_ecc_pkg::data_flags_t'(rand_word()), hci_ecc_pkg::data_flags_t'(rand_word()),
            hci_ecc_pkg::meta_flags_t'(rand_word()), hci_ecc_pkg::meta_flags_t'(rand_word()));
    end
    read_all();
    end_test();

    begin_test("write_preset");
    write_reg(hci_ecc_pkg::REG_DATA_CORR, 32'hDEAD_BEEF, 4'hF, 4'h1);
    write_reg(hci_ecc_pkg::REG_META_UNCORR, 32'h1234_5678, 4'hF, 4'h2);
    read_all();
    write_reg(hci_ecc_pkg::REG_DATA_CORR, '0, 4'hF, 4'h3);
    write_reg(hci_ecc_pkg::REG_META_UNCORR, 32'hAABB_CCDD, 4'b0101, 4'h4);
    write_reg(hci_ecc_pkg::REG_DATA_UNCORR, 32'hFFFF_FFFE, 4'hF, 4'h5);
    // Eight data flags push the preset value past the wrap point
    apply(1'b0, 1'b1, '0, '0, '0, '0, 8'hFF, 8'hFF, 2'b00, 2'b00);
    read_all();
    end_test();

    begin_test("write_collision");
    // A low byte of FF lets a carry from the increment reach the byte the write leaves alone
    write_reg(hci_ecc_pkg::REG_META_CORR, 32'h0000_01FF, 4'hF, 4'h5);
    apply(1'b1, 1'b0, hci_ecc_pkg::REG_DATA_UNCORR, 32'h0000_0100, 4'hF, 4'h6,
          8'hFF, 8'hFF, 2'b11, 2'b11);
    apply(1'b1, 1'b0, hci_ecc_pkg::REG_META_CORR, 32'h0000_0055, 4'b0001, 4'h7,
          8'h0F, 8'h0F, 2'b11, 2'b01);
    read_all();
    end_test();

    begin_test("unmapped");
    read_reg(32'h0000_0010, 4'h1);
    read_reg(32'h0000_0002, 4'h2);
    read_reg(32'h8000_0004, 4'h3);
    write_reg(32'h0000_0014, 32'h5A5A_5A5A, 4'hF, 4'h4);
    read_all();
    end_test();

    begin_test("back_to_back");
    for (int i = 0; i < 24; i++) begin
      r = rand_word();
      apply(1'b1, r[8] | r[9], hci_ecc_pkg::addr_t'({r[5:4], 2'b00}), rand_word(), r[15:12],
            r[19:16], hci_ecc_pkg::data_flags_t'(rand_word()),
            hci_ecc_pkg::data_flags_t'(rand_word()), r[21:20], r[23:22]);
    end
    read_all();
    end_test();

    $display("Summary: %0d tests, %0d failed, %0d check errors", test_cnt, test_fail_cnt,
             err_cnt);
    if (err_cnt == 0 && test_fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/hci_ecc_manager.sv */
`timescale 1ns/1ps
`default_nettype none

module hci_ecc_manager (
  input  wire logic                     clk_i,
  input  wire logic                     arst_n_i,

  // Peripheral request/grant port
  input  wire logic                     periph_req_i,
  input  wire hci_ecc_pkg::addr_t       periph_add_i,
  input  wire logic                     periph_wen_i,
  input  wire hci_ecc_pkg::data_t       periph_wdata_i,
  input  wire hci_ecc_pkg::be_t         periph_be_i,
  input  wire hci_ecc_pkg::id_t         periph_id_i,
  output logic                          periph_gnt_o,
  output hci_ecc_pkg::data_t            periph_r_rdata_o,
  output logic                          periph_r_opc_o,
  output hci_ecc_pkg::id_t              periph_r_id_o,
  output logic                          periph_r_valid_o,

  // Error flags sampled from the ECC decoders every cycle
  input  wire hci_ecc_pkg::data_flags_t data_correctable_err_i,
  input  wire hci_ecc_pkg::data_flags_t data_uncorrectable_err_i,
  input  wire hci_ecc_pkg::meta_flags_t meta_correctable_err_i,
  input  wire hci_ecc_pkg::meta_flags_t meta_uncorrectable_err_i
);

  logic               reg_valid;
  logic               reg_write;
  hci_ecc_pkg::addr_t reg_addr;
  hci_ecc_pkg::data_t reg_wdata;
  hci_ecc_pkg::be_t   reg_be;
  hci_ecc_pkg::data_t reg_rdata;
  logic               reg_error;

  hci_ecc_pkg::cnt_t  data_corr_num;
  hci_ecc_pkg::cnt_t  data_uncorr_num;
  hci_ecc_pkg::cnt_t  meta_corr_num;
  hci_ecc_pkg::cnt_t  meta_uncorr_num;

  periph_to_reg i_periph_to_reg (
    .clk_i            ( clk_i            ),
    .arst_n_i         ( arst_n_i         ),
    .periph_req_i     ( periph_req_i     ),
    .periph_add_i     ( periph_add_i     ),
    .periph_wen_i     ( periph_wen_i     ),
    .periph_wdata_i   ( periph_wdata_i   ),
    .periph_be_i      ( periph_be_i      ),
    .periph_id_i      ( periph_id_i      ),
    .periph_gnt_o     ( periph_gnt_o     ),
    .periph_r_rdata_o ( periph_r_rdata_o ),
    .periph_r_opc_o   ( periph_r_opc_o   ),
    .periph_r_id_o    ( periph_r_id_o    ),
    .periph_r_valid_o ( periph_r_valid_o ),
    .reg_valid_o      ( reg_valid        ),
    .reg_write_o      ( reg_write        ),
    .reg_addr_o       ( reg_addr         ),
    .reg_wdata_o      ( reg_wdata        ),
    .reg_be_o         ( reg_be           ),
    .reg_rdata_i      ( reg_rdata        ),
    .reg_error_i      ( reg_error        )
  );

  hci_ecc_manager_reg_top i_registers (
    .clk_i             ( clk_i           ),
    .arst_n_i          ( arst_n_i        ),
    .reg_valid_i       ( reg_valid       ),
    .reg_write_i       ( reg_write       ),
    .reg_addr_i        ( reg_addr        ),
    .reg_wdata_i       ( reg_wdata       ),
    .reg_be_i          ( reg_be          ),
    .reg_rdata_o       ( reg_rdata       ),
    .reg_error_o       ( reg_error       ),
    .data_corr_num_i   ( data_corr_num   ),
    .data_uncorr_num_i ( data_uncorr_num ),
    .meta_corr_num_i   ( meta_corr_num   ),
    .meta_uncorr_num_i ( meta_uncorr_num )
  );

  // One counter of set flags per error group
  popcount #(
    .INPUT_WIDTH ( hci_ecc_pkg::N_DATA_FLAGS )
  ) i_popcount_data_corr (
    .data_i     ( data_correctable_err_i ),
    .popcount_o ( data_corr_num          )
  );

  popcount #(
    .INPUT_WIDTH ( hci_ecc_pkg::N_DATA_FLAGS )
  ) i_popcount_data_uncorr (
    .data_i     ( data_uncorrectable_err_i ),
    .popcount_o ( data_uncorr_num          )
  );

  popcount #(
    .INPUT_WIDTH ( hci_ecc_pkg::PAR_META )
  ) i_popcount_meta_corr (
    .data_i     ( meta_correctable_err_i ),
    .popcount_o ( meta_corr_num          )
  );

  popcount #(
    .INPUT_WIDTH ( hci_ecc_pkg::PAR_META )
  ) i_popcount_meta_uncorr (
    .data_i     ( meta_uncorrectable_err_i ),
    .popcount_o ( meta_uncorr_num          )
  );

endmodule

`default_nettype wire

/* verilog/hci_ecc_manager_reg_top.sv */
`timescale 1ns/1ps
`default_nettype none

module hci_ecc_manager_reg_top (
  input  wire logic               clk_i,
  input  wire logic               arst_n_i,

  // Register strobe from the bus bridge
  input  wire logic               reg_valid_i,
  input  wire logic               reg_write_i,
  input  wire hci_ecc_pkg::addr_t reg_addr_i,
  input  wire hci_ecc_pkg::data_t reg_wdata_i,
  input  wire hci_ecc_pkg::be_t   reg_be_i,
  output hci_ecc_pkg::data_t      reg_rdata_o,
  output logic                    reg_error_o,

  // Per-cycle increments from the popcount units
  input  wire hci_ecc_pkg::cnt_t  data_corr_num_i,
  input  wire hci_ecc_pkg::cnt_t  data_uncorr_num_i,
  input  wire hci_ecc_pkg::cnt_t  meta_corr_num_i,
  input  wire hci_ecc_pkg::cnt_t  meta_uncorr_num_i
);

  hci_ecc_pkg::cnt_t                   cnt_q   [hci_ecc_pkg::N_CNT];
  hci_ecc_pkg::cnt_t                   cnt_d   [hci_ecc_pkg::N_CNT];
  hci_ecc_pkg::cnt_t                   inc     [hci_ecc_pkg::N_CNT];
  hci_ecc_pkg::cnt_t                   wr_word [hci_ecc_pkg::N_CNT];
  logic [hci_ecc_pkg::N_CNT-1:0]       addr_hit;
  logic [hci_ecc_pkg::N_CNT-1:0]       wr_sel;

  // Increments in register order
  assign inc[hci_ecc_pkg::IDX_DATA_CORR]   = data_corr_num_i;
  assign inc[hci_ecc_pkg::IDX_DATA_UNCORR] = data_uncorr_num_i;
  assign inc[hci_ecc_pkg::IDX_META_CORR]   = meta_corr_num_i;
  assign inc[hci_ecc_pkg::IDX_META_UNCORR] = meta_uncorr_num_i;

  // A full-address compare keeps stray upper or low bits from hitting a counter
  assign addr_hit[hci_ecc_pkg::IDX_DATA_CORR]   = (reg_addr_i == hci_ecc_pkg::REG_DATA_CORR);
  assign addr_hit[hci_ecc_pkg::IDX_DATA_UNCORR] = (reg_addr_i == hci_ecc_pkg::REG_DATA_UNCORR);
  assign addr_hit[hci_ecc_pkg::IDX_META_CORR]   = (reg_addr_i == hci_ecc_pkg::REG_META_CORR);
  assign addr_hit[hci_ecc_pkg::IDX_META_UNCORR] = (reg_addr_i == hci_ecc_pkg::REG_META_UNCORR);

  assign wr_sel = addr_hit & {hci_ecc_pkg::N_CNT{reg_valid_i & reg_write_i}};

  // Byte merge of the software write with the stored value
  // Disabled bytes keep the old count rather than the incremented one
  always_comb begin
    for (int unsigned i = 0; i < hci_ecc_pkg::N_CNT; i++) begin
      wr_word[i] = cnt_q[i];
      for (int unsigned b = 0; b < hci_ecc_pkg::BW; b++) begin
        if (reg_be_i[b]) begin
          wr_word[i][8*b +: 8] = reg_wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Software write wins over that cycle's increments
  always_comb begin
    for (int unsigned i = 0; i < hci_ecc_pkg::N_CNT; i++) begin
      if (wr_sel[i]) begin
        cnt_d[i] = wr_word[i];
      end else if (inc[i] != '0) begin
        cnt_d[i] = cnt_q[i] + inc[i];
      end else begin
        cnt_d[i] = cnt_q[i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int unsigned i = 0; i < hci_ecc_pkg::N_CNT; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int unsigned i = 0; i < hci_ecc_pkg::N_CNT; i++) begin
        cnt_q[i] <= cnt_d[i];
      end
    end
  end

  // Read mux sees the value before this cycle's update
  always_comb begin
    reg_rdata_o = '0;
    reg_error_o = 1'b0;
    case (reg_addr_i)
      hci_ecc_pkg::REG_DATA_CORR:   reg_rdata_o = cnt_q[hci_ecc_pkg::IDX_DATA_CORR];
      hci_ecc_pkg::REG_DATA_UNCORR: reg_rdata_o = cnt_q[hci_ecc_pkg::IDX_DATA_UNCORR];
      hci_ecc_pkg::REG_META_CORR:   reg_rdata_o = cnt_q[hci_ecc_pkg::IDX_META_CORR];
      hci_ecc_pkg::REG_META_UNCORR: reg_rdata_o = cnt_q[hci_ecc_pkg::IDX_META_UNCORR];
      default: begin
        // Unmapped offsets read as zero and flag the error
        reg_error_o = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

/* verilog/hci_ecc_pkg.sv */
`default_nettype none

package hci_ecc_pkg;

  // ECC granularity and port counts of the memory interconnect
  localparam int unsigned N_CHUNK  = 2;
  localparam int unsigned PAR_DATA = 4;
  localparam int unsigned PAR_META = 2;

  // One flag per chunk per data port for each error kind
  localparam int unsigned N_DATA_FLAGS = PAR_DATA * N_CHUNK;

  // Peripheral bus widths
  localparam int unsigned AW = 32;
  localparam int unsigned DW = 32;
  localparam int unsigned BW = 4;
  localparam int unsigned IW = 4;

  // Error counters are full words and wrap around
  localparam int unsigned CNT_W = 32;

  typedef logic [AW-1:0]           addr_t;
  typedef logic [DW-1:0]           data_t;
  typedef logic [BW-1:0]           be_t;
  typedef logic [IW-1:0]           id_t;
  typedef logic [CNT_W-1:0]        cnt_t;
  typedef logic [N_DATA_FLAGS-1:0] data_flags_t;
  typedef logic [PAR_META-1:0]     meta_flags_t;

  // Register map, one word per counter
  localparam addr_t REG_DATA_CORR   = 32'h0000_0000;
  localparam addr_t REG_DATA_UNCORR = 32'h0000_0004;
  localparam addr_t REG_META_CORR   = 32'h0000_0008;
  localparam addr_t REG_META_UNCORR = 32'h0000_000C;

  // Counter slots inside the register file
  localparam int unsigned N_CNT          = 4;
  localparam int unsigned IDX_DATA_CORR   = 0;
  localparam int unsigned IDX_DATA_UNCORR = 1;
  localparam int unsigned IDX_META_CORR   = 2;
  localparam int unsigned IDX_META_UNCORR = 3;

endpackage

`default_nettype wire

/* verilog/periph_to_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module periph_to_reg (
  input  wire logic               clk_i,
  input  wire logic               arst_n_i,

  // Peripheral request/grant port
  input  wire logic               periph_req_i,
  input  wire hci_ecc_pkg::addr_t periph_add_i,
  input  wire logic               periph_wen_i,
  input  wire hci_ecc_pkg::data_t periph_wdata_i,
  input  wire hci_ecc_pkg::be_t   periph_be_i,
  input  wire hci_ecc_pkg::id_t   periph_id_i,
  output logic                    periph_gnt_o,
  output hci_ecc_pkg::data_t      periph_r_rdata_o,
  output logic                    periph_r_opc_o,
  output hci_ecc_pkg::id_t        periph_r_id_o,
  output logic                    periph_r_valid_o,

  // Register strobe side
  output logic                    reg_valid_o,
  output logic                    reg_write_o,
  output hci_ecc_pkg::addr_t      reg_addr_o,
  output hci_ecc_pkg::data_t      reg_wdata_o,
  output hci_ecc_pkg::be_t        reg_be_o,
  input  wire hci_ecc_pkg::data_t reg_rdata_i,
  input  wire logic               reg_error_i
);

  logic               r_valid_q;
  logic               r_opc_q;
  hci_ecc_pkg::data_t r_rdata_q;
  hci_ecc_pkg::id_t   r_id_q;

  // The register file never stalls so every request is granted on the spot
  assign periph_gnt_o = periph_req_i;

  // A granted request becomes a single-cycle strobe
  // The bus uses wen high for reads and the register side wants a write flag
  assign reg_valid_o = periph_req_i;
  assign reg_write_o = ~periph_wen_i;
  assign reg_addr_o  = periph_add_i;
  assign reg_wdata_o = periph_wdata_i;
  assign reg_be_o    = periph_be_i;

  // Response control is valid exactly one cycle after the grant
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      r_valid_q <= 1'b0;
      r_opc_q   <= 1'b0;
    end else begin
      r_valid_q <= periph_req_i;
      if (periph_req_i) begin
        r_opc_q <= reg_error_i;
      end
    end
  end

  // Writes return zero data in the response payload
  always_ff @(posedge clk_i) begin
    if (periph_req_i) begin
      r_rdata_q <= periph_wen_i ? reg_rdata_i : '0;
      r_id_q    <= periph_id_i;
    end
  end

  assign periph_r_valid_o = r_valid_q;
  assign periph_r_opc_o   = r_opc_q;
  assign periph_r_rdata_o = r_rdata_q;
  assign periph_r_id_o    = r_id_q;

endmodule

`default_nettype wire

/* verilog/popcount.sv */
`timescale 1ns/1ps
`default_nettype none

module popcount #(
  parameter int unsigned INPUT_WIDTH = 1
) (
  input  wire logic [INPUT_WIDTH-1:0] data_i,
  output hci_ecc_pkg::cnt_t           popcount_o
);

  hci_ecc_pkg::cnt_t sum;

  // Ripple of single-bit adds over the flag vector
  always_comb begin
    sum = '0;
    for (int unsigned i = 0; i < INPUT_WIDTH; i++) begin
      if (data_i[i]) begin
        sum = sum + hci_ecc_pkg::cnt_t'(1);
      end
    end
  end

  // Result is zero-extended to counter width so it can feed the adders directly
  assign popcount_o = sum;

endmodule

`default_nettype wire
